/* Makefile */
TOP := tb_u1e_ctrl

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f u1e_ctrl.f

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 | \
	  awk '{ print } /^Testbench passed$$/ { ok = 1 } END { exit !ok }'

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f u1e_ctrl.f

clean:
	rm -rf obj_dir

/* dv/tb_u1e_ctrl.sv */
////////////////////
// control plane testbench: bus master tasks, register
// model with reference reads, time and pps checks
////////////////////

`timescale 1ns/10ps

module tb_u1e_ctrl;

   import u1e_bus_pkg::*;
   import u1e_settings_pkg::*;

   localparam logic [31:0]   TICKS      = 32'd1000;
   localparam int            CLK_PERIOD = 20;
   localparam int            DRIVE_DLY  = 1;
   localparam int            MAX_WAIT   = 4;   // cycles an access may wait for ack
   // reset, misc, test32, time, pps, unmapped
   localparam int            TEST_CYCLES     = 40 + 200 + 40 + 80 + 160 + 20;
   localparam int            WATCHDOG_CYCLES = 2 * TEST_CYCLES + 50;
   localparam logic [AW-1:0] RB_BASE         = 11'h380;   // slave 7

   logic          wb_clk = 1'b0;
   logic          wb_rst;
   logic [AW-1:0] wb_adr_i;
   logic [DW-1:0] wb_dat_i, wb_dat_o;
   logic          wb_we_i, wb_cyc_i, wb_stb_i, wb_ack_o;
   logic          cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i, pps_i;
   logic [15:0]   rx_frame_len_i, tx_frame_len_o;
   logic [3:0]    debug_led_o, test_ctrl_o;
   logic          cgen_sync_b_o, cgen_ref_sel_o;
   logic [7:0]    test_rate_o;

   ////////////////////
   // register model and check queue

   logic [15:0] m_leds, m_cgen, m_test, m_txlen, m_xfer;
   logic [31:0] m_test32;
   logic [31:0] lfsr = 32'h137230a2;

   string       name_q[$];
   logic [31:0] exp_q[$];
   logic [31:0] act_q[$];
   int          checks_queued = 0;
   int          checks_done = 0;
   int          errors = 0;
   int          test_errors = 0;
   int          tests_run = 0;

   u1e_ctrl_top #(.TICKS_PER_SEC(TICKS)) dut (.*);

   always #(CLK_PERIOD / 2) wb_clk = ~wb_clk;

   // galois lfsr, one step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      int          i;
      r = '0;
      for (i = 0; i < n; i++)
      begin
         r    = {r[30:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      end
      return r;
   endfunction

   function automatic logic [15:0] rand16();
      logic [31:0] r;
      r = rand_bits(16);
      return r[15:0];
   endfunction

   // setting address sits on byte address bits 7:2 of slaves 8/9
   function automatic logic [AW-1:0] set_adr(input logic [7:0] addr, input logic high);
      return {3'b100, addr[5:0], high, 1'b0};
   endfunction

   // expected read data from the register model
   function automatic logic [15:0] ref_read(input logic [AW-1:0] adr);
      logic [31:0] w;
      w = '0;
      if (adr[AW-1 -: DECODE_W] == 4'd0)
      begin
         case (adr[6:0])
            REG_LEDS:        return m_leds;
            REG_CGEN_CTRL:   return m_cgen;
            REG_CGEN_ST:     return {13'h0, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
            REG_TEST:        return m_test;
            REG_RX_FRAMELEN: return rx_frame_len_i;
            REG_TX_FRAMELEN: return m_txlen;
            REG_XFER_RATE:   return m_xfer;
            REG_COMPAT:      return 16'd5;
            default:         return 16'hBEEF;
         endcase
      end
      if (adr[AW-1 -: DECODE_W] == 4'd7 && adr[5:2] == 4'd4)
         w = m_test32;
      return adr[1] ? w[31:16] : w[15:0];
   endfunction

   task automatic check_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      if (exp !== act)
      begin
         errors++;
         test_errors++;
         $display("Fail %s: expected %0h, actual %0h", name, exp, act);
      end
   endtask

   task automatic expect_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
      name_q.push_back(name);
      exp_q.push_back(exp);
      act_q.push_back(act);
      checks_queued++;
   endtask

   // comparing process
   initial
   begin
      forever
      begin
         wait (checks_queued != checks_done);
         check_value(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
         checks_done++;
      end
   end

   ////////////////////
   // bus master

   // entered and left at DRIVE_DLY after a rising edge
   task automatic bus_access(input logic we, input logic [AW-1:0] adr,
                             input logic [DW-1:0] dat, output logic [DW-1:0] rdat,
                             output logic acked);
      int n;
      n        = 0;
      acked    = 1'b0;
      rdat     = '0;
      wb_adr_i = adr;
      wb_dat_i = dat;
      wb_we_i  = we;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      while (!acked && n < MAX_WAIT)
      begin
         @(negedge wb_clk);
         if (wb_ack_o)
         begin
            acked = 1'b1;
            rdat  = wb_dat_o;   // valid in the ack cycle
         end
         @(posedge wb_clk);
         n++;
      end
      #DRIVE_DLY;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic access_checked(input logic we, input logic [AW-1:0] adr,
                                 input logic [DW-1:0] dat, output logic [DW-1:0] rdat);
      logic acked;
      bus_access(we, adr, dat, rdat, acked);
      if (!acked)
      begin
         errors++;
         test_errors++;
         $display("bus access to address %h was never acknowledged", adr);
      end
   endtask

   task automatic write_misc(input logic [6:0] off, input logic [15:0] dat);
      logic [DW-1:0] unused;
      access_checked(1'b1, {4'h0, off}, dat, unused);
      case (off)
         REG_LEDS:        m_leds  = dat;
         REG_CGEN_CTRL:   m_cgen  = dat;
         REG_TEST:        m_test  = dat;
         REG_TX_FRAMELEN: m_txlen = dat;
         REG_XFER_RATE:   m_xfer  = dat;
         default:         ;
      endcase
   endtask

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      logic [DW-1:0] unused;
      access_checked(1'b1, set_adr(addr, 1'b0), data[15:0], unused);
      access_checked(1'b1, set_adr(addr, 1'b1), data[31:16], unused);
   endtask

   task automatic read_check(input string name, input logic [AW-1:0] adr);
      logic [DW-1:0] rdat;
      access_checked(1'b0, adr, '0, rdat);
      expect_value(name, 32'(ref_read(adr)), 32'(rdat));
   endtask

   task automatic read32(input int word, output logic [31:0] val);
      logic [DW-1:0] lo, hi;
      logic [AW-1:0] adr;
      adr = RB_BASE + AW'(word * 4);
      access_checked(1'b0, adr, '0, lo);
      access_checked(1'b0, adr + AW'(2), '0, hi);
      val = {hi, lo};
   endtask

   task automatic read_all_misc(input string tag);
      logic [6:0] offs [10];
      int         i;
      offs = '{REG_LEDS, REG_CGEN_CTRL, REG_CGEN_ST, REG_TEST, REG_RX_FRAMELEN,
               REG_TX_FRAMELEN, REG_XFER_RATE, REG_COMPAT, 7'd2, 7'd18};
      for (i = 0; i < 10; i++)
         read_check($sformatf("%s offset %0d", tag, offs[i]), {4'h0, offs[i]});
   endtask

   task automatic check_outputs(input string tag);
      expect_value({tag, " leds"}, {28'h0, ~m_leds[3:0]}, 32'(debug_led_o));   // active low
      expect_value({tag, " sync_b"}, 32'(m_cgen[1]), 32'(cgen_sync_b_o));
      expect_value({tag, " ref_sel"}, 32'(m_cgen[0]), 32'(cgen_ref_sel_o));
      expect_value({tag, " tx_frame_len"}, 32'(m_txlen), 32'(tx_frame_len_o));
      expect_value({tag, " test_rate"}, 32'(m_xfer[7:0]), 32'(test_rate_o));
      expect_value({tag, " test_ctrl"}, 32'(m_xfer[11:8]), 32'(test_ctrl_o));
   endtask

   task automatic apply_reset();
      wb_rst = 1'b1;
      repeat (8) @(posedge wb_clk);
      #DRIVE_DLY;
      wb_rst  = 1'b0;
      m_leds  = '0;
      m_cgen  = 16'd3;
      m_test  = '0;
      m_txlen = '0;
      m_xfer  = '0;
   endtask

   task automatic idle(input int n);
      repeat (n) @(posedge wb_clk);
      #DRIVE_DLY;
   endtask

   task automatic finish_test(input string name);
      wait (checks_done == checks_queued);
      $display("test %-9s : %0d errors", name, test_errors);
      tests_run++;
      test_errors = 0;
   endtask

   ////////////////////
   // tests

   initial
   begin
      logic [31:0]   secs, ticks, s_load, r;
      logic [DW-1:0] rdat;
      logic          acked;
      int            total;
      wb_rst           = 1'b1;
      wb_adr_i         = '0;
      wb_dat_i         = '0;
      wb_we_i          = 1'b0;
      wb_cyc_i         = 1'b0;
      wb_stb_i         = 1'b0;
      cgen_st_status_i = 1'b0;
      cgen_st_ld_i     = 1'b0;
      cgen_st_refmon_i = 1'b0;
      rx_frame_len_i   = '0;
      pps_i            = 1'b0;
      apply_reset();

      read_all_misc("reset");
      check_outputs("reset");
      finish_test("reset");

      repeat (3)
      begin
         write_misc(REG_LEDS, rand16());
         write_misc(REG_CGEN_CTRL, rand16());
         write_misc(REG_TEST, rand16());
         write_misc(REG_TX_FRAMELEN, rand16());
         write_misc(REG_XFER_RATE, rand16());
         r = rand_bits(3);
         {cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i} = r[2:0];
         rx_frame_len_i = rand16();
         read_all_misc("misc");
         check_outputs("misc");
      end
      finish_test("misc");

      // strobe one cycle after the high ack, register one cycle later
      m_test32 = rand_bits(32);
      write_setting(SR_REG_TEST32, m_test32);
      idle(2);
      read_check("test32 low", RB_BASE + 11'h010);
      read_check("test32 high", RB_BASE + 11'h012);
      apply_reset();
      read_check("test32 low after reset", RB_BASE + 11'h010);
      read_check("test32 high after reset", RB_BASE + 11'h012);
      finish_test("test32");

      s_load = rand_bits(20);
      write_setting(SR_TIME64, s_load);
      write_setting(SR_TIME64 + 8'd1, 32'd990);
      idle(30);   // past the wrap, well short of the next one
      read32(0, secs);
      read32(1, ticks);
      expect_value("time seconds", s_load + 32'd1, secs);
      expect_value("time ticks below 1000", 32'd1, 32'(ticks < TICKS));
      finish_test("time");

      read32(2, secs);
      read32(3, ticks);
      expect_value("pps seconds before pulse", 32'd0, secs);
      expect_value("pps ticks before pulse", 32'd0, ticks);
      s_load = rand_bits(20);
      write_setting(SR_TIME64, s_load);
      write_setting(SR_TIME64 + 8'd1, 32'd0);
      idle(100);
      pps_i = 1'b1;
      idle(4);
      pps_i = 1'b0;
      idle(4);
      read32(2, secs);
      read32(3, ticks);
      expect_value("pps seconds", s_load, secs);
      expect_value("pps ticks within 1..500", 32'd1,
                   32'(ticks >= 32'd1 && ticks <= 32'd500));
      finish_test("pps");

      bus_access(1'b0, 11'h180, '0, rdat, acked);   // select 3
      expect_value("unmapped access acked", 32'd0, 32'(acked));
      read_check("compat after unmapped", {4'h0, REG_COMPAT});
      finish_test("unmapped");

      total = errors + int'(dut.u_checker.assert_errors);
      $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
               tests_run, checks_done, errors, dut.u_checker.assert_errors);
      if (total == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

   // watchdog
   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, the tests did not complete",
               WATCHDOG_CYCLES);
      $display("Testbench failed");
      $finish;
   end

endmodule

/* dv/u1e_ctrl_checker.sv */
////////////////////
// bus and reset properties of the control plane,
// bound onto the top level
////////////////////

`timescale 1ns/10ps

module u1e_ctrl_checker
   (input logic                       wb_clk,
    input logic                       wb_rst,
    input logic [u1e_bus_pkg::AW-1:0] wb_adr_i,
    input logic                       wb_cyc_i,
    input logic                       wb_stb_i,
    input logic                       wb_ack_o,
    input logic                       cgen_sync_b_o,
    input logic                       cgen_ref_sel_o);

   import u1e_bus_pkg::*;

   int unsigned         assert_errors = 0;
   logic [DECODE_W-1:0] sel;
   logic                mapped;

   assign sel    = wb_adr_i[AW-1 -: DECODE_W];
   // slaves 0, 7, 8 and 9
   assign mapped = (sel == 4'd0) || (sel == 4'd7) || (sel == 4'd8) || (sel == 4'd9);

   ack_needs_request: assert property (@(posedge wb_clk) disable iff (wb_rst)
         wb_ack_o |-> (wb_cyc_i && wb_stb_i))
      else
      begin
         $error("ack seen without cyc and stb");
         assert_errors++;
      end

   // clock generator comes out of reset with sync_b and ref_sel high
   cgen_after_reset: assert property (@(posedge wb_clk)
         wb_rst |=> (cgen_sync_b_o && cgen_ref_sel_o))
      else
      begin
         $error("clock generator outputs not high after reset");
         assert_errors++;
      end

   unmapped_no_ack: assert property (@(posedge wb_clk) disable iff (wb_rst)
         (wb_cyc_i && wb_stb_i && !mapped) |-> !wb_ack_o)
      else
      begin
         $error("unmapped select was acked");
         assert_errors++;
      end

endmodule

bind u1e_ctrl_top u1e_ctrl_checker u_checker
  (.wb_clk(wb_clk), .wb_rst(wb_rst), .wb_adr_i(wb_adr_i), .wb_cyc_i(wb_cyc_i),
   .wb_stb_i(wb_stb_i), .wb_ack_o(wb_ack_o), .cgen_sync_b_o(cgen_sync_b_o),
   .cgen_ref_sel_o(cgen_ref_sel_o));

/* rtl/misc_ctrl_regs.sv */
////////////////////
// slave 0 register bank: leds, clock generator
// control and status, test and transfer-rate words
////////////////////

`timescale 1ns/10ps

module misc_ctrl_regs
   (input  logic                       wb_clk,
    input  logic                       wb_rst,
    input  logic                       stb_i,
    input  logic                       we_i,
    input  logic [6:0]                 adr_i,
    input  logic [u1e_bus_pkg::DW-1:0] dat_i,
    input  logic                       cgen_st_status_i,
    input  logic                       cgen_st_ld_i,
    input  logic                       cgen_st_refmon_i,
    input  logic [15:0]                rx_frame_len_i,
    output logic [u1e_bus_pkg::DW-1:0] dat_o,
    output logic [3:0]                 debug_led_o,
    output logic                       cgen_sync_b_o,
    output logic                       cgen_ref_sel_o,
    output logic [15:0]                tx_frame_len_o,
    output logic [7:0]                 test_rate_o,
    output logic [3:0]                 test_ctrl_o);

   import u1e_bus_pkg::*;

   logic [DW-1:0] reg_leds, reg_cgen_ctrl, reg_test, reg_tx_framelen, reg_xfer_rate;

   ////////////////////
   // writes

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         reg_leds        <= '0;
         reg_cgen_ctrl   <= 16'd3;   // sync_b and ref_sel high
         reg_test        <= '0;
         reg_tx_framelen <= '0;
         reg_xfer_rate   <= '0;
      end
      else if (stb_i && we_i)
      begin
         case (adr_i)
            REG_LEDS:        reg_leds        <= dat_i;
            REG_CGEN_CTRL:   reg_cgen_ctrl   <= dat_i;
            REG_TEST:        reg_test        <= dat_i;
            REG_TX_FRAMELEN: reg_tx_framelen <= dat_i;
            REG_XFER_RATE:   reg_xfer_rate   <= dat_i;
            default:         ;               // read-only or unmapped
         endcase
      end
   end

   assign debug_led_o    = ~reg_leds[3:0];   // lamps are active low
   assign cgen_sync_b_o  = reg_cgen_ctrl[1];
   assign cgen_ref_sel_o = reg_cgen_ctrl[0];
   assign tx_frame_len_o = reg_tx_framelen;
   assign test_ctrl_o    = reg_xfer_rate[11:8];
   assign test_rate_o    = reg_xfer_rate[7:0];

   ////////////////////
   // reads

   always_comb
   begin
      case (adr_i)
         REG_LEDS:        dat_o = reg_leds;
         REG_CGEN_CTRL:   dat_o = reg_cgen_ctrl;
         REG_CGEN_ST:     dat_o = {{(DW-3){1'b0}}, cgen_st_status_i, cgen_st_ld_i,
                                   cgen_st_refmon_i};
         REG_TEST:        dat_o = reg_test;
         REG_RX_FRAMELEN: dat_o = rx_frame_len_i;
         REG_TX_FRAMELEN: dat_o = reg_tx_framelen;
         REG_XFER_RATE:   dat_o = reg_xfer_rate;
         REG_COMPAT:      dat_o = {{(DW-8){1'b0}}, COMPAT_NUM};
         default:         dat_o = READ_FILL;
      endcase
   end

endmodule

/* rtl/readback_mux_16le.sv */
////////////////////
// slave 7: 32-bit readback words over a 16-bit
// bus, plus the test setting that survives reset
////////////////////

`timescale 1ns/10ps

module readback_mux_16le
   (input  logic                                wb_clk,
    input  logic                                set_stb_i,
    input  logic [u1e_settings_pkg::SET_AW-1:0] set_addr_i,
    input  logic [u1e_settings_pkg::SET_DW-1:0] set_data_i,
    input  logic [5:0]                          adr_i,
    input  u1e_settings_pkg::vita_time_u        vita_time_i,
    input  u1e_settings_pkg::vita_time_u        vita_time_pps_i,
    output logic [u1e_bus_pkg::DW-1:0]          dat_o);

   import u1e_settings_pkg::*;

   logic [SET_DW-1:0] test32;
   logic [31:0]       word;

   // software reads it back to tell whether the fpga was reloaded
   always_ff @(posedge wb_clk)
   begin
      if (set_stb_i && (set_addr_i == SR_REG_TEST32))
      begin
         test32 <= set_data_i;
      end
   end

   ////////////////////
   // word select

   always_comb
   begin
      case (adr_i[5:2])
         4'd0:    word = vita_time_i.word[1];       // seconds
         4'd1:    word = vita_time_i.word[0];       // ticks
         4'd2:    word = vita_time_pps_i.word[1];
         4'd3:    word = vita_time_pps_i.word[0];
         4'd4:    word = test32;
         default: word = '0;
      endcase
   end

   // little endian halves
   assign dat_o = adr_i[1] ? word[31:16] : word[15:0];

endmodule

/* rtl/settings_bus_16le.sv */
////////////////////
// 16-bit settings port: the low half is held, the
// high half write issues a 32-bit setting strobe
////////////////////

`timescale 1ns/10ps

module settings_bus_16le
   (input  logic                                 wb_clk,
    input  logic                                 wb_rst,
    input  logic                                 stb_i,
    input  logic                                 we_i,
    input  logic [7:1]                           adr_i,   // byte address bits
    input  logic [u1e_bus_pkg::DW-1:0]           dat_i,
    output logic                                 set_stb_o,
    output logic [u1e_settings_pkg::SET_AW-1:0]  set_addr_o,
    output logic [u1e_settings_pkg::SET_DW-1:0]  set_data_o);

   import u1e_bus_pkg::*;
   import u1e_settings_pkg::*;

   logic [DW-1:0] low_half;
   logic          wr_low, wr_high;

   assign wr_low  = stb_i & we_i & ~adr_i[1];
   assign wr_high = stb_i & we_i & adr_i[1];

   // low half waits for its partner
   always_ff @(posedge wb_clk)
   begin
      if (wr_low)
      begin
         low_half <= dat_i;
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (wr_high)
      begin
         set_addr_o <= {{(SET_AW-6){1'b0}}, adr_i[7:2]};
         set_data_o <= {dat_i, low_half};
      end
   end

   // one-cycle strobe after the high half ack
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         set_stb_o <= 1'b0;
      else
         set_stb_o <= wr_high;
   end

endmodule

/* rtl/u1e_bus_pkg.sv */
////////////////////
// control bus definitions: widths, slave select codes,
// misc register offsets and the compatibility number
////////////////////

package u1e_bus_pkg;

   ////////////////////
   // bus geometry

   parameter int DW = 16;        // data width
   parameter int AW = 11;        // byte address width
   parameter int DECODE_W = 4;   // select field, top address bits

   ////////////////////
   // slave select codes

   parameter logic [DECODE_W-1:0] SLV_MISC     = 4'd0;
   parameter logic [DECODE_W-1:0] SLV_READBACK = 4'd7;
   parameter logic [DECODE_W-1:0] SLV_SETTINGS = 4'd8;  // 8 and 9, low bit ignored

   ////////////////////
   // slave 0 byte offsets

   parameter logic [6:0] REG_LEDS        = 7'd0;   // rw
   parameter logic [6:0] REG_CGEN_CTRL   = 7'd4;   // rw
   parameter logic [6:0] REG_CGEN_ST     = 7'd6;   // ro
   parameter logic [6:0] REG_TEST        = 7'd8;   // rw
   parameter logic [6:0] REG_RX_FRAMELEN = 7'd10;  // ro
   parameter logic [6:0] REG_TX_FRAMELEN = 7'd12;  // rw
   parameter logic [6:0] REG_XFER_RATE   = 7'd14;  // rw
   parameter logic [6:0] REG_COMPAT      = 7'd16;  // ro

   // bump when the register map changes
   parameter logic [7:0] COMPAT_NUM = 8'd5;

   parameter logic [DW-1:0] READ_FILL = 16'hBEEF;  // undecoded offsets

endpackage

/* rtl/u1e_ctrl_top.sv */
////////////////////
// control plane top: bus decode, misc registers,
// settings bus, timekeeper and readback mux
////////////////////

`timescale 1ns/10ps

module u1e_ctrl_top
  #(parameter logic [31:0] TICKS_PER_SEC = 32'd64000000)
   (input  logic                       wb_clk,
    input  logic                       wb_rst,
    input  logic [u1e_bus_pkg::AW-1:0] wb_adr_i,
    input  logic [u1e_bus_pkg::DW-1:0] wb_dat_i,
    input  logic                       wb_we_i,
    input  logic                       wb_cyc_i,
    input  logic                       wb_stb_i,
    output logic [u1e_bus_pkg::DW-1:0] wb_dat_o,
    output logic                       wb_ack_o,
    input  logic                       cgen_st_status_i,
    input  logic                       cgen_st_ld_i,
    input  logic                       cgen_st_refmon_i,
    input  logic [15:0]                rx_frame_len_i,
    input  logic                       pps_i,
    output logic [3:0]                 debug_led_o,
    output logic                       cgen_sync_b_o,
    output logic                       cgen_ref_sel_o,
    output logic [15:0]                tx_frame_len_o,
    output logic [7:0]                 test_rate_o,
    output logic [3:0]                 test_ctrl_o);

   import u1e_bus_pkg::*;
   import u1e_settings_pkg::*;

   logic              misc_stb, set_stb_bus;
   logic [DW-1:0]     misc_dat, rb_dat;

   logic              set_stb;
   logic [SET_AW-1:0] set_addr;
   logic [SET_DW-1:0] set_data;

   vita_time_u        vita_time, vita_time_pps;

   ////////////////////
   // bus decode

   wb_slave_decode u_decode
     (.wb_adr_i(wb_adr_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
      .misc_dat_i(misc_dat), .rb_dat_i(rb_dat),
      .misc_stb_o(misc_stb), .rb_stb_o(),   // readback mux is purely combinational
      .set_stb_o(set_stb_bus), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o));

   ////////////////////
   // slave 0

   misc_ctrl_regs u_misc
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .stb_i(misc_stb), .we_i(wb_we_i), .adr_i(wb_adr_i[6:0]), .dat_i(wb_dat_i),
      .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i), .rx_frame_len_i(rx_frame_len_i),
      .dat_o(misc_dat), .debug_led_o(debug_led_o),
      .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o),
      .tx_frame_len_o(tx_frame_len_o), .test_rate_o(test_rate_o),
      .test_ctrl_o(test_ctrl_o));

   ////////////////////
   // slaves 8 and 9

   settings_bus_16le u_settings
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .stb_i(set_stb_bus), .we_i(wb_we_i), .adr_i(wb_adr_i[7:1]), .dat_i(wb_dat_i),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data));

   ////////////////////
   // timekeeping

   vita_time_64 #(.TICKS_PER_SEC(TICKS_PER_SEC)) u_time
     (.wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .pps_i(pps_i), .vita_time_o(vita_time), .vita_time_pps_o(vita_time_pps));

   ////////////////////
   // slave 7

   readback_mux_16le u_readback
     (.wb_clk(wb_clk),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .adr_i(wb_adr_i[5:0]), .vita_time_i(vita_time), .vita_time_pps_i(vita_time_pps),
      .dat_o(rb_dat));

endmodule

/* rtl/u1e_settings_pkg.sv */
////////////////////
// settings bus definitions: addresses, widths
// and the two views of a 64-bit VITA time word
////////////////////

package u1e_settings_pkg;

   ////////////////////
   // settings bus geometry

   parameter int SET_AW = 8;
   parameter int SET_DW = 32;

   ////////////////////
   // setting addresses

   // +0 pending seconds, +1 ticks and commit
   parameter logic [SET_AW-1:0] SR_TIME64     = 8'd42;
   parameter logic [SET_AW-1:0] SR_REG_TEST32 = 8'd60;  // survives reset

   ////////////////////
   // vita time

   // counter view
   typedef struct packed {
      logic [31:0] secs;   // upper word
      logic [31:0] ticks;  // lower word
   } vita_time_t;

   // word[1] holds seconds, word[0] holds ticks
   typedef union packed {
      vita_time_t       t;
      logic [1:0][31:0] word;
   } vita_time_u;

endpackage

/* rtl/vita_time_64.sv */
////////////////////
// 64-bit seconds/ticks timekeeper, loaded through
// settings, with time capture on a pps rising edge
////////////////////

`timescale 1ns/10ps

module vita_time_64
  #(parameter logic [31:0] TICKS_PER_SEC = 32'd64000000)
   (input  logic                                wb_clk,
    input  logic                                wb_rst,
    input  logic                                set_stb_i,
    input  logic [u1e_settings_pkg::SET_AW-1:0] set_addr_i,
    input  logic [u1e_settings_pkg::SET_DW-1:0] set_data_i,
    input  logic                                pps_i,
    output u1e_settings_pkg::vita_time_u        vita_time_o,
    output u1e_settings_pkg::vita_time_u        vita_time_pps_o);

   import u1e_settings_pkg::*;

   logic [31:0] secs_pending;
   logic        ld_secs, ld_commit;
   logic        pps_q, pps_d, pps_edge;
   vita_time_u  now;

   assign ld_secs   = set_stb_i && (set_addr_i == SR_TIME64);
   assign ld_commit = set_stb_i && (set_addr_i == SR_TIME64 + SET_AW'(1));

   always_ff @(posedge wb_clk)
   begin
      if (ld_secs)
      begin
         secs_pending <= set_data_i;
      end
   end

   ////////////////////
   // counter

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         now <= '0;
      else if (ld_commit)
      begin
         now.t.secs  <= secs_pending;   // both halves land together
         now.t.ticks <= set_data_i;
      end
      else if (now.t.ticks == TICKS_PER_SEC - 32'd1)
      begin
         now.t.ticks <= '0;
         now.t.secs  <= now.t.secs + 32'd1;
      end
      else
         now.t.ticks <= now.t.ticks + 32'd1;
   end

   ////////////////////
   // pps capture

   assign pps_edge = pps_q & ~pps_d;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_q           <= 1'b0;
         pps_d           <= 1'b0;
         vita_time_pps_o <= '0;
      end
      else
      begin
         pps_q <= pps_i;   // async input
         pps_d <= pps_q;
         if (pps_edge)
            vita_time_pps_o <= now;
      end
   end

   assign vita_time_o = now;

endmodule

/* rtl/wb_slave_decode.sv */
////////////////////
// single master decode: slave strobes from the
// top address bits, one-cycle ack and read data mux
////////////////////

`timescale 1ns/10ps

module wb_slave_decode
   (input  logic [u1e_bus_pkg::AW-1:0] wb_adr_i,
    input  logic                       wb_cyc_i,
    input  logic                       wb_stb_i,
    input  logic [u1e_bus_pkg::DW-1:0] misc_dat_i,
    input  logic [u1e_bus_pkg::DW-1:0] rb_dat_i,
    output logic                       misc_stb_o,
    output logic                       rb_stb_o,
    output logic                       set_stb_o,
    output logic [u1e_bus_pkg::DW-1:0] wb_dat_o,
    output logic                       wb_ack_o);

   import u1e_bus_pkg::*;

   logic [DECODE_W-1:0] sel;
   logic                access;

   assign sel    = wb_adr_i[AW-1 -: DECODE_W];
   assign access = wb_cyc_i & wb_stb_i;

   assign misc_stb_o = access && (sel == SLV_MISC);
   assign rb_stb_o   = access && (sel == SLV_READBACK);

   // settings slave is double wide, select bit 0 becomes setting addr bit 5
   assign set_stb_o  = access && (sel[DECODE_W-1:1] == SLV_SETTINGS[DECODE_W-1:1]);

   // every mapped slave answers in the strobe cycle
   assign wb_ack_o = misc_stb_o | rb_stb_o | set_stb_o;

   ////////////////////
   // read data

   always_comb
   begin
      wb_dat_o = '0;   // settings reads return zero
      if (misc_stb_o)
      begin
         wb_dat_o = misc_dat_i;
      end
      else if (rb_stb_o)
      begin
         wb_dat_o = rb_dat_i;
      end
   end

endmodule

/* u1e_ctrl.f */
rtl/u1e_bus_pkg.sv
rtl/u1e_settings_pkg.sv
rtl/wb_slave_decode.sv
rtl/misc_ctrl_regs.sv
rtl/settings_bus_16le.sv
rtl/vita_time_64.sv
rtl/readback_mux_16le.sv
rtl/u1e_ctrl_top.sv
dv/u1e_ctrl_checker.sv
dv/tb_u1e_ctrl.sv
